//--- hdl/bar_fill_ctrl.sv
// test bar fill FSM writing the frame buffer in blanking, owns the memory port
`default_nettype none

module bar_fill_ctrl (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  blank,
   input  logic  bar_period,
   vram_if.arb    rd_side,
   vram_if.writer mem,
   output logic  fill_busy
);

   // payload bits not carrying pixels
   localparam int PAD_W = vfb_pkg::VRAM_DATA_W - vfb_pkg::PIX_PER_WORD * vfb_pkg::PIXEL_W;

   vfb_pkg::fill_state_t state;
   vfb_pkg::vram_addr_t  fill_addr;
   logic                 period_q;
   logic                 write_en;
   logic                 last_addr;
   vfb_pkg::pixel_t      bar_byte;
   vfb_pkg::vram_word_t  bar_word;

   //////////////////////////////
   // fill FSM
   //////////////////////////////

   // one word per blank cycle while filling
   assign write_en  = (state == vfb_pkg::fill_run) & blank;
   // fill covers the whole memory
   assign last_addr = &fill_addr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= vfb_pkg::fill_idle;
         fill_addr <= '0;
         period_q  <= 1'b0;
      end else begin
         case (state)
            vfb_pkg::fill_idle: begin
               // first fill after reset
               state     <= vfb_pkg::fill_run;
               fill_addr <= '0;
               period_q  <= bar_period;
            end
            vfb_pkg::fill_run: begin
               if (write_en) begin
                  fill_addr <= fill_addr + 1'b1;
                  if (last_addr) begin
                     state <= vfb_pkg::fill_done;
                  end
               end
            end
            vfb_pkg::fill_done: begin
               // new bar width, start over from address 0
               if (bar_period != period_q) begin
                  state     <= vfb_pkg::fill_run;
                  fill_addr <= '0;
                  period_q  <= bar_period;
               end
            end
            default: begin
               state <= vfb_pkg::fill_idle;
            end
         endcase
      end
   end

   assign fill_busy = (state != vfb_pkg::fill_done);

   //////////////////////////////
   // bar pattern
   //////////////////////////////

   // grey level from address bits, narrow bars for period 1
   always_comb begin
      if (period_q) begin
         bar_byte = {fill_addr[6:3], 4'b0000};
      end else begin
         bar_byte = {fill_addr[7:4], 4'b0000};
      end
   end

   // same level in all four pixels of the word
   assign bar_word = {{PAD_W{1'b0}}, {vfb_pkg::PIX_PER_WORD{bar_byte}}};

   //////////////////////////////
   // memory port mux
   //////////////////////////////

   // writes steal the port, reads pass through otherwise
   assign mem.addr  = write_en ? fill_addr : rd_side.addr;
   assign mem.we    = write_en;
   assign mem.wdata = bar_word;

   // read data goes back to the display side untouched
   assign rd_side.rdata = mem.rdata;

endmodule

`default_nettype wire

//--- hdl/pixel_out.sv
// registered output stage selecting frame buffer or hardwired bars, with syncs
`default_nettype none

module pixel_out #(
   parameter int HW_BAR_LSB = 6
) (
   input  logic             clk,
   input  logic             rst_n,
   input  vfb_pkg::hcount_t hcount,
   input  vfb_pkg::pixel_t  vr_pixel,
   input  logic             hsync,
   input  logic             vsync,
   input  logic             blank,
   input  logic             vbar_mode,
   output vfb_pkg::pixel_t  vga_pixel,
   output logic             vga_hsync,
   output logic             vga_vsync,
   output logic             vga_blank
);

   vfb_pkg::pixel_t hw_bar;

   // three count bits give eight grey steps across the line
   assign hw_bar = {hcount[HW_BAR_LSB+2:HW_BAR_LSB], {(vfb_pkg::PIXEL_W-3){1'b0}}};

   // pixel, syncs and blank move together so they stay aligned
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vga_pixel <= '0;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_blank <= 1'b0;
      end else begin
         vga_pixel <= vbar_mode ? hw_bar : vr_pixel;
         vga_hsync <= hsync;
         vga_vsync <= vsync;
         vga_blank <= blank;
      end
   end

endmodule

`default_nettype wire

//--- hdl/vfb_pkg.sv
// frame buffer video core shared widths, vector types and fill FSM states
`default_nettype none

package vfb_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   // raster counters, wide enough for xga totals
   localparam int HCOUNT_W     = 11;
   localparam int VCOUNT_W     = 10;

   // one grey pixel, four of them per memory word
   localparam int PIXEL_W      = 8;
   localparam int PIX_PER_WORD = 4;

   // zbt style frame memory port
   localparam int VRAM_ADDR_W  = 19;
   localparam int VRAM_DATA_W  = 36;

   // address is looked up this many pixel clocks early
   localparam int FORECAST     = 8;
   // cycles from address to read data
   localparam int READ_LATENCY = 2;

   //////////////////////////////
   // types
   //////////////////////////////

   typedef logic [HCOUNT_W-1:0]    hcount_t;
   typedef logic [VCOUNT_W-1:0]    vcount_t;
   typedef logic [PIXEL_W-1:0]     pixel_t;
   typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
   typedef logic [VRAM_DATA_W-1:0] vram_word_t;

   // test bar fill FSM
   typedef enum logic [1:0] {
      fill_idle,
      fill_run,
      fill_done
   } fill_state_t;

endpackage

`default_nettype wire

//--- hdl/video_fb_top.sv
// frame buffer display core top with timing, reader, bar fill and output stage
`default_nettype none

module video_fb_top #(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806,
   parameter int HW_BAR_LSB   = 6
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                bar_period,
   input  logic                vbar_mode,
   input  vfb_pkg::vram_word_t vram_rdata,
   output vfb_pkg::vram_addr_t vram_addr,
   output logic                vram_we,
   output vfb_pkg::vram_word_t vram_wdata,
   output vfb_pkg::pixel_t     vga_pixel,
   output logic                vga_hsync,
   output logic                vga_vsync,
   output logic                vga_blank,
   output logic                fill_busy
);

   vfb_pkg::hcount_t hcount;
   vfb_pkg::vcount_t vcount;
   logic             hsync;
   logic             vsync;
   logic             blank;
   vfb_pkg::pixel_t  vr_pixel;

   // reader to arbiter, and arbiter to the pins
   vram_if u_rd_if ();
   vram_if u_ext_if ();

   //////////////////////////////
   // raster timing
   //////////////////////////////

   video_timing #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL)
   ) u_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   //////////////////////////////
   // frame buffer path
   //////////////////////////////

   vram_reader #(
      .H_TOTAL (H_TOTAL),
      .V_TOTAL (V_TOTAL)
   ) u_reader (
      .clk      (clk),
      .rst_n    (rst_n),
      .hcount   (hcount),
      .vcount   (vcount),
      .mem      (u_rd_if.reader),
      .vr_pixel (vr_pixel)
   );

   // fill writes only while blank, so display reads are undisturbed
   bar_fill_ctrl u_fill (
      .clk        (clk),
      .rst_n      (rst_n),
      .blank      (blank),
      .bar_period (bar_period),
      .rd_side    (u_rd_if.arb),
      .mem        (u_ext_if.writer),
      .fill_busy  (fill_busy)
   );

   // external memory pins
   assign vram_addr       = u_ext_if.addr;
   assign vram_we         = u_ext_if.we;
   assign vram_wdata      = u_ext_if.wdata;
   assign u_ext_if.rdata  = vram_rdata;

   //////////////////////////////
   // output stage
   //////////////////////////////

   pixel_out #(
      .HW_BAR_LSB (HW_BAR_LSB)
   ) u_out (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .vr_pixel  (vr_pixel),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .vbar_mode (vbar_mode),
      .vga_pixel (vga_pixel),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_blank (vga_blank)
   );

endmodule

`default_nettype wire

//--- hdl/video_timing.sv
// video timing generator with pixel/line counters, active low syncs and blank
`default_nettype none

module video_timing #(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806
) (
   input  logic             clk,
   input  logic             rst_n,
   output vfb_pkg::hcount_t hcount,
   output vfb_pkg::vcount_t vcount,
   output logic             hsync,
   output logic             vsync,
   output logic             blank
);

   //////////////////////////////
   // compare points
   //////////////////////////////

   logic line_end;
   logic frame_end;
   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;
   logic hblank;
   logic vblank;
   logic hblank_nxt;
   logic vblank_nxt;

   // flags are registered, so each fires one count before its edge
   assign line_end  = (hcount == vfb_pkg::hcount_t'(H_TOTAL - 1));
   assign hblank_on = (hcount == vfb_pkg::hcount_t'(H_ACTIVE - 1));
   assign hsync_on  = (hcount == vfb_pkg::hcount_t'(H_SYNC_START - 1));
   assign hsync_off = (hcount == vfb_pkg::hcount_t'(H_SYNC_END - 1));

   // vertical flags only move on the last pixel of a line
   assign frame_end = line_end & (vcount == vfb_pkg::vcount_t'(V_TOTAL - 1));
   assign vblank_on = line_end & (vcount == vfb_pkg::vcount_t'(V_ACTIVE - 1));
   assign vsync_on  = line_end & (vcount == vfb_pkg::vcount_t'(V_SYNC_START - 1));
   assign vsync_off = line_end & (vcount == vfb_pkg::vcount_t'(V_SYNC_END - 1));

   // next blank state, so blank lines up with the count it belongs to
   assign hblank_nxt = line_end ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign vblank_nxt = frame_end ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   //////////////////////////////
   // counters and flags
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         blank  <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
      end else begin
         hcount <= line_end ? '0 : hcount + 1'b1;
         if (line_end) begin
            vcount <= frame_end ? '0 : vcount + 1'b1;
         end
         hblank <= hblank_nxt;
         vblank <= vblank_nxt;
         blank  <= hblank_nxt | vblank_nxt;
         // syncs are active low
         if (hsync_on) begin
            hsync <= 1'b0;
         end else if (hsync_off) begin
            hsync <= 1'b1;
         end
         if (vsync_on) begin
            vsync <= 1'b0;
         end else if (vsync_off) begin
            vsync <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/vram_if.sv
// frame memory port bundle shared by reader, fill controller and top level
`default_nettype none

interface vram_if;

   // word address, valid every cycle
   vfb_pkg::vram_addr_t addr;
   // write strobe, one word per cycle
   logic                we;
   vfb_pkg::vram_word_t wdata;
   // read word for the address issued READ_LATENCY cycles earlier
   vfb_pkg::vram_word_t rdata;

   // display side, only reads
   modport reader (
      output addr,
      input  rdata
   );

   // owner of the external memory pins
   modport writer (
      output addr,
      output we,
      output wdata,
      input  rdata
   );

   // arbiter view of the reader, takes its address and returns data
   modport arb (
      input  addr,
      output rdata
   );

endinterface

`default_nettype wire

//--- hdl/vram_reader.sv
// frame buffer reader with forecast address, word latches and pixel unpack
`default_nettype none

module vram_reader #(
   parameter int H_TOTAL = 1344,
   parameter int V_TOTAL = 806
) (
   input  logic             clk,
   input  logic             rst_n,
   input  vfb_pkg::hcount_t hcount,
   input  vfb_pkg::vcount_t vcount,
   vram_if.reader           mem,
   output vfb_pkg::pixel_t  vr_pixel
);

   // bits of the count that pick a byte inside a word
   localparam int SEL_W = $clog2(vfb_pkg::PIX_PER_WORD);
   // forecast runs past the line end from here on
   localparam vfb_pkg::hcount_t H_WRAP = vfb_pkg::hcount_t'(H_TOTAL - vfb_pkg::FORECAST);
   // address goes out at phase 3, data is back READ_LATENCY later
   localparam logic [SEL_W-1:0] LATCH_PHASE = SEL_W'(3 + vfb_pkg::READ_LATENCY);
   localparam logic [SEL_W-1:0] SHOW_PHASE  = '1;

   //////////////////////////////
   // address forecast
   //////////////////////////////

   vfb_pkg::hcount_t   hcount_f;
   vfb_pkg::vcount_t   vcount_f;
   logic [SEL_W-1:0]   phase;
   vfb_pkg::vram_word_t word_latched;
   vfb_pkg::vram_word_t word_shown;

   assign phase = hcount[SEL_W-1:0];

   // look FORECAST pixels ahead, wrap into next line and frame
   always_comb begin
      if (hcount >= H_WRAP) begin
         hcount_f = hcount - H_WRAP;
         vcount_f = (vcount == vfb_pkg::vcount_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
      end else begin
         hcount_f = hcount + vfb_pkg::hcount_t'(vfb_pkg::FORECAST);
         vcount_f = vcount;
      end
   end

   // line number then word number within the line
   assign mem.addr = vfb_pkg::vram_addr_t'({vcount_f, hcount_f[vfb_pkg::HCOUNT_W-1:SEL_W]});

   //////////////////////////////
   // word latches
   //////////////////////////////

   // catch rdata once per word, then hold it for a whole group of four
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         word_latched <= '0;
         word_shown   <= '0;
      end else begin
         if (phase == LATCH_PHASE) begin
            word_latched <= mem.rdata;
         end
         // handover on the last pixel of the current word
         if (phase == SHOW_PHASE) begin
            word_shown <= word_latched;
         end
      end
   end

   // leftmost pixel lives in the top byte, parity bits unused
   always_comb begin
      case (phase)
         2'd0:    vr_pixel = word_shown[31:24];
         2'd1:    vr_pixel = word_shown[23:16];
         2'd2:    vr_pixel = word_shown[15:8];
         default: vr_pixel = word_shown[7:0];
      endcase
   end

endmodule

`default_nettype wire

//--- sim.f
hdl/vfb_pkg.sv
hdl/vram_if.sv
hdl/video_timing.sv
hdl/vram_reader.sv
hdl/bar_fill_ctrl.sv
hdl/pixel_out.sv
hdl/video_fb_top.sv
verification/vram_model.sv
verification/tb_video_fb.sv

//--- verification/display_patterns.txt
// columns, all hex: bar_period  vbar_mode  frames to observe
// a row of ff ff ff ends the table
00 00 02
00 01 02
01 00 02
01 01 01
00 00 02
ff ff ff

//--- verification/tb_video_fb.sv
// testbench for the frame buffer video core, driven row by row from a pattern file
`default_nettype none

module tb_video_fb;

   timeunit 1ns;
   timeprecision 100ps;

   // small raster keeps a frame at a few hundred cycles
   localparam int H_ACTIVE     = 32;
   localparam int H_SYNC_START = 36;
   localparam int H_SYNC_END   = 40;
   localparam int H_TOTAL      = 48;
   localparam int V_ACTIVE     = 8;
   localparam int V_SYNC_START = 9;
   localparam int V_SYNC_END   = 10;
   localparam int V_TOTAL      = 12;
   localparam int HW_BAR_LSB   = 2;

   localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
   localparam int BLANK_CYC  = FRAME_CYC - H_ACTIVE * V_ACTIVE;
   // whole memory written, one word per blank cycle
   localparam int FILL_CYC   = ((1 << vfb_pkg::VRAM_ADDR_W) + BLANK_CYC - 1) / BLANK_CYC
                               * FRAME_CYC;
   localparam int FILL_LIMIT = FILL_CYC + FRAME_CYC;
   localparam int MAX_ROWS   = 16;

   // pixel check modes
   localparam int CHK_OFF = 0;
   localparam int CHK_FB  = 1;
   localparam int CHK_HW  = 2;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                bar_period;
   logic                vbar_mode;
   vfb_pkg::vram_word_t vram_rdata;
   vfb_pkg::vram_addr_t vram_addr;
   logic                vram_we;
   vfb_pkg::vram_word_t vram_wdata;
   vfb_pkg::pixel_t     vga_pixel;
   logic                vga_hsync;
   logic                vga_vsync;
   logic                vga_blank;
   logic                fill_busy;

   // three entries per row: bar_period, vbar_mode, frames
   logic [7:0]  pat_mem [0:3*MAX_ROWS-1];
   int          watchdog_cycles = 0;
   int          fail_count = 0;
   int unsigned seed;
   int unsigned rnd;

   // monitor state, written only by the negedge monitor
   logic mon_on = 1'b0;
   int   check_mode = CHK_OFF;
   logic check_period = 1'b0;
   int   cyc = 0;
   int   px = 0;
   int   line_idx = 0;
   int   since_rise = 0;
   logic rise_seen = 1'b0;
   int   last_hs_fall = -1;
   int   hs_low = 0;
   int   vs_low = 0;
   int   pix_checked = 0;
   int   wr_addr = 0;
   logic blank_prev = 1'b0;
   logic hs_prev = 1'b1;
   logic vs_prev = 1'b1;
   logic we_prev = 1'b0;
   logic busy_prev = 1'b1;

   always #10 clk = ~clk;

   video_fb_top #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL),
      .HW_BAR_LSB   (HW_BAR_LSB)
   ) u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .bar_period (bar_period),
      .vbar_mode  (vbar_mode),
      .vram_rdata (vram_rdata),
      .vram_addr  (vram_addr),
      .vram_we    (vram_we),
      .vram_wdata (vram_wdata),
      .vga_pixel  (vga_pixel),
      .vga_hsync  (vga_hsync),
      .vga_vsync  (vga_vsync),
      .vga_blank  (vga_blank),
      .fill_busy  (fill_busy)
   );

   vram_model u_vram (
      .clk   (clk),
      .addr  (vram_addr),
      .we    (vram_we),
      .wdata (vram_wdata),
      .rdata (vram_rdata)
   );

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic end_in_failure();
      fail_count++;
      $display("Simulation failed");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
         end_in_failure();
      end
   endtask

   // wait for fill_busy to reach a level, sampled 2 ns after the edge
   task automatic wait_fill_level(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (fill_busy !== level) begin
         if (n == limit) begin
            $display("ERROR: %s within %0d cycles", what, limit);
            end_in_failure();
         end
         @(posedge clk);
         #2;
         n++;
      end
   endtask

   // grey level of a word address, from bits 6..3 or 7..4
   function automatic logic [7:0] bar_level(input logic [18:0] addr, input logic period);
      if (period) begin
         return {addr[6:3], 4'b0000};
      end
      return {addr[7:4], 4'b0000};
   endfunction

   // word address is line then pixel/4
   function automatic logic [7:0] expected_bar(input int ln, input int pix, input logic period);
      logic [18:0] addr;
      addr = {ln[9:0], pix[10:2]};
      return bar_level(addr, period);
   endfunction

   // eight grey steps from three pixel number bits
   function automatic logic [7:0] expected_hw_bar(input int pix);
      logic [31:0] p;
      p = pix;
      return {p[HW_BAR_LSB+2 -: 3], 5'b00000};
   endfunction

   //////////////////////////////
   // output monitor
   //////////////////////////////

   // outputs move on the rising edge, so look at them on the falling one
   always @(negedge clk) begin
      if (mon_on) begin
         cyc = cyc + 1;
         if (we_prev) begin
            check_value(vga_blank, 1'b1, "vram_we outside blanking");
         end
         // a fill walks up from address 0, four copies of the bar level per word
         if (fill_busy && !busy_prev) begin
            wr_addr = 0;
         end
         if (vram_we) begin
            check_value(vram_addr, wr_addr, "fill write address");
            check_value(vram_wdata, {4'h0, {4{bar_level(vram_addr, bar_period)}}},
                        "fill write data");
            wr_addr++;
         end
         if (!vga_blank) begin
            if (check_mode == CHK_FB) begin
               check_value(vga_pixel, expected_bar(line_idx, px, check_period),
                           "frame buffer pixel");
               pix_checked++;
            end else if (check_mode == CHK_HW) begin
               check_value(vga_pixel, expected_hw_bar(px), "hardwired bar pixel");
               pix_checked++;
            end
            px++;
         end
         // end of the active part of a line
         if (vga_blank && !blank_prev) begin
            check_value(px, H_ACTIVE, "active pixels in line");
            px = 0;
            line_idx++;
            since_rise = 0;
            rise_seen = 1'b1;
         end else begin
            since_rise++;
         end
         if (!vga_hsync && hs_prev) begin
            if (rise_seen) begin
               check_value(since_rise, H_SYNC_START - H_ACTIVE, "hsync start after blank");
            end
            rise_seen = 1'b0;
            if (last_hs_fall >= 0) begin
               check_value(cyc - last_hs_fall, H_TOTAL, "line period");
            end
            last_hs_fall = cyc;
            hs_low = 0;
         end
         if (vga_hsync && !hs_prev) begin
            check_value(hs_low, H_SYNC_END - H_SYNC_START, "hsync width");
         end
         if (!vga_hsync) begin
            hs_low++;
         end
         if (!vga_vsync && vs_prev) begin
            check_value(line_idx, V_ACTIVE, "active lines in frame");
            vs_low = 0;
         end
         // vsync back high, next active line is line 0
         if (vga_vsync && !vs_prev) begin
            check_value(vs_low, (V_SYNC_END - V_SYNC_START) * H_TOTAL, "vsync width");
            line_idx = 0;
         end
         if (!vga_vsync) begin
            vs_low++;
         end
         blank_prev = vga_blank;
         hs_prev    = vga_hsync;
         vs_prev    = vga_vsync;
         we_prev    = vram_we;
         busy_prev  = fill_busy;
      end
   end

   //////////////////////////////
   // watchdog
   //////////////////////////////

   initial begin
      wait (watchdog_cycles != 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("ERROR: run timed out after %0d cycles", watchdog_cycles);
      end_in_failure();
   end

   //////////////////////////////
   // stimulus
   //////////////////////////////

   initial begin
      int   rows;
      int   fills;
      int   total_frames;
      int   wait_cyc;
      logic prev_bp;
      $timeformat(-9, 1, " ns", 10);
      rst_n      = 1'b0;
      bar_period = 1'b0;
      vbar_mode  = 1'b0;
      seed       = 77856;
      rnd        = $urandom(seed);
      for (int i = 0; i < 3 * MAX_ROWS; i++) begin
         pat_mem[i] = 8'hff;
      end
      $readmemh("verification/display_patterns.txt", pat_mem);
      rows = 0;
      fills = 1;
      total_frames = 0;
      prev_bp = 1'b0;
      // a row of ff ends the table
      while (rows < MAX_ROWS && pat_mem[3*rows] != 8'hff) begin
         if (pat_mem[3*rows][0] != prev_bp) begin
            fills++;
         end
         prev_bp = pat_mem[3*rows][0];
         total_frames += pat_mem[3*rows+2];
         rows++;
      end
      if (rows == 0) begin
         $display("ERROR: no test rows found in the pattern file");
         end_in_failure();
      end
      watchdog_cycles = 2 * (total_frames + 3 * rows) * FRAME_CYC + fills * FILL_LIMIT;

      // state inside reset
      @(negedge clk);
      check_value(vga_hsync, 1'b1, "vga_hsync in reset");
      check_value(vga_vsync, 1'b1, "vga_vsync in reset");
      check_value(vram_we, 1'b0, "vram_we in reset");
      check_value(fill_busy, 1'b1, "fill_busy in reset");
      @(posedge clk);
      #2;
      rst_n = 1'b1;
      // count 0 reaches the outputs one edge later
      @(posedge clk);
      #2;
      mon_on = 1'b1;

      prev_bp = 1'b0;
      for (int r = 0; r < rows; r++) begin
         wait_fill_level(1'b0, FILL_LIMIT, "fill_busy did not fall");
         @(negedge vga_vsync);
         rnd = $urandom;
         wait_cyc = rnd % FRAME_CYC;
         repeat (wait_cyc + 1) @(posedge clk);
         #2;
         bar_period = pat_mem[3*r][0];
         vbar_mode  = pat_mem[3*r+1][0];
         if (bar_period != prev_bp) begin
            // new bar width restarts the fill
            wait_fill_level(1'b1, 3, "fill_busy did not rise after a bar_period change");
            wait_fill_level(1'b0, FILL_LIMIT, "refill did not finish");
         end
         prev_bp = bar_period;
         // observe whole frames from one vsync rise to another
         @(posedge vga_vsync);
         #2;
         check_period = bar_period;
         check_mode = vbar_mode ? CHK_HW : CHK_FB;
         repeat (pat_mem[3*r+2]) @(posedge vga_vsync);
         #2;
         check_mode = CHK_OFF;
      end
      check_value(pix_checked, total_frames * H_ACTIVE * V_ACTIVE, "active pixels checked");

      if (fail_count == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         end_in_failure();
      end
   end

endmodule

`default_nettype wire

//--- verification/vram_model.sv
// frame memory model, one word port with a fixed two cycle read latency
`default_nettype none

module vram_model (
   input  logic                clk,
   input  vfb_pkg::vram_addr_t addr,
   input  logic                we,
   input  vfb_pkg::vram_word_t wdata,
   output vfb_pkg::vram_word_t rdata
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DEPTH = 1 << vfb_pkg::VRAM_ADDR_W;

   vfb_pkg::vram_word_t mem [0:DEPTH-1];
   // first read stage, rdata is the second
   vfb_pkg::vram_word_t rd_stage;

   // start with a non bar pattern so a missed write shows up on screen
   initial begin
      for (int a = 0; a < DEPTH; a++) begin
         mem[a] = {~a[16:0], a[18:0]};
      end
      rd_stage = '0;
      rdata    = '0;
   end

   // word for addr of cycle n is on rdata during cycle n+2
   always @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rd_stage <= mem[addr];
      rdata    <= rd_stage;
   end

endmodule

`default_nettype wire
